// ==== compile.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/riscv_core.sv
bench/core_checker.sv
bench/core_tb.sv

// ==== Makefile ====
TOP = core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TESTS PASSED$$'

clean:
	rm -rf obj_dir

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb import isa_pkg::*; ();

	logic   clock;
	logic   reset;
	word_t  pc;
	word_t  instr;
	word_t  mem_addr;
	word_t  mem_wdata;
	logic   mem_read;
	logic   mem_write;
	word_t  mem_rdata;

	word_t  prog [0:63];
	word_t  dmem [0:15];
	word_t  rd_data;
	logic   prog_valid;
	logic   done;
	int     tests_run;
	int     tests_failed;
	integer seed;

	riscv_core DUT (
		.clock     (clock),
		.reset     (reset),
		.pc        (pc),
		.instr     (instr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_rdata (mem_rdata)
	);

	core_checker u_check (
		.clock        (clock),
		.reset        (reset),
		.pc           (pc),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.prog         (prog),
		.prog_valid   (prog_valid),
		.done         (done),
		.tests_run    (tests_run),
		.tests_failed (tests_failed)
	);

	always #20 clock = ~clock;

	// every bit of the word index shows up in the word
	function automatic word_t data_fill(logic [3:0] idx);
		return {4'ha, idx, 8'h3c, ~idx, idx, 4'h5, idx ^ 4'h6};
	endfunction

	function automatic logic [2:0] pick_f3(logic [2:0] s);
		case (s)
			3'd2: return 3'b010;
			3'd3: return 3'b100;
			3'd4: return 3'b110;
			3'd5: return 3'b111;
			default: return 3'b000;
		endcase
	endfunction

	function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// 7 register seeds, 48 random, 8 dump stores, final self loop
	task automatic gen_program();
		word_t      r;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] load_rd;
		logic       after_load;
		logic [2:0] f3;
		int         tgt;
		int         ob;
		after_load = 1'b0;
		load_rd = 5'd0;
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			rd = {2'b00, r[2:0]};
			// the instruction right after a load reads its result
			rs1 = after_load ? load_rd : {2'b00, r[5:3]};
			rs2 = (r[26:25] == 2'b11) ? rs1 : {2'b00, r[8:6]};
			f3 = pick_f3(r[11:9]);
			tgt = i + 2 + int'(r[18:17] % 2'd3);
			if (tgt > 55) begin
				tgt = 55;
			end
			ob = (tgt - i) * 4;
			after_load = 1'b0;
			if (i < 7) begin
				prog[i] = enc_i(r[31:20], 5'd0, 3'b000, 5'(i + 1), 7'b0010011);
			end else if (i == 63) begin
				prog[i] = enc_j(21'd0, 5'd0);
			end else if (i >= 55) begin
				// dump x0..x7 above the random data words
				prog[i] = enc_s(12'(32 + (i - 55) * 4), 5'(i - 55), 5'd0);
			end else begin
				case (r[16:13])
					4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
						prog[i] = enc_r({1'b0, r[12] && f3 == 3'b000, 5'b00000},
							rs2, rs1, f3, rd);
					end
					4'd5, 4'd6, 4'd7: begin
						prog[i] = enc_i({{4{r[24]}}, r[24:17]}, rs1, f3, rd, 7'b0010011);
					end
					4'd8, 4'd9: begin
						prog[i] = enc_i({7'd0, r[19:17], 2'b00}, 5'd0, 3'b010, rd,
							7'b0000011);
						after_load = 1'b1;
						load_rd = rd;
					end
					4'd10, 4'd11: begin
						prog[i] = enc_s({7'd0, r[19:17], 2'b00}, rs2, 5'd0);
					end
					4'd12, 4'd13, 4'd14: begin
						prog[i] = enc_b(13'(ob), rs2, rs1);
					end
					default: begin
						prog[i] = enc_j(21'(ob), rd);
					end
				endcase
			end
		end
	endtask

	// instruction and data memories, load data one cycle after the read
	always @(negedge clock) begin
		instr <= prog[pc[7:2]];
		mem_rdata <= rd_data;
		if (mem_read) begin
			rd_data = dmem[mem_addr[5:2]];
		end
		if (mem_write) begin
			dmem[mem_addr[5:2]] = mem_wdata;
		end
	end

	initial begin
		int guard;
		clock = 1'b0;
		reset <= 1'b0;
		instr <= '0;
		mem_rdata <= '0;
		rd_data = '0;
		prog_valid = 1'b0;
		seed = 32'h8f9c4b1a;
		gen_program();
		for (int i = 0; i < 16; i++) begin
			dmem[i] = data_fill(4'(i));
		end
		prog_valid = 1'b1;
		repeat (5) @(negedge clock);
		reset <= 1'b1;
		guard = 0;
		while (!done && guard < 4000) begin
			@(negedge clock);
			guard++;
		end
		if (!done) begin
			$display("the checker gave no result within 4000 cycles");
		end
		$display("%0d tests run, %0d passed, %0d failed", tests_run,
			tests_run - tests_failed, tests_failed);
		if (done && tests_failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== bench/core_checker.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_checker import isa_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  word_t pc,
	input  logic  mem_read,
	input  logic  mem_write,
	input  word_t mem_addr,
	input  word_t mem_wdata,
	input  word_t prog [0:63],
	input  logic  prog_valid,
	output logic  done,
	output int    tests_run,
	output int    tests_failed
);

	word_t xr [0:31];
	word_t dm [0:15];
	word_t exp_addr_q [$];
	word_t exp_data_q [$];
	word_t final_pc;
	logic  model_ok;
	int    stores_seen = 0;
	int    store_errors = 0;
	int    stores_expected = 0;

	// same fill as the data memory of the bench
	function automatic word_t data_fill(logic [3:0] idx);
		return {4'ha, idx, 8'h3c, ~idx, idx, 4'h5, idx ^ 4'h6};
	endfunction

	function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			3'b111: return a & b;
			default: return a + b;
		endcase
	endfunction

	// runs the program one instruction per step
	task automatic build_model();
		word_t mpc;
		word_t nxt;
		word_t ins;
		word_t a;
		word_t b;
		word_t res;
		word_t addr;
		word_t imm_i;
		word_t imm_s;
		word_t imm_b;
		word_t imm_j;
		logic  wr;
		logic  stop;
		int    steps;
		for (int i = 0; i < 32; i++) begin
			xr[i] = '0;
		end
		for (int i = 0; i < 16; i++) begin
			dm[i] = data_fill(4'(i));
		end
		mpc = `CORE_RESET_PC;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < 500) begin
			ins = prog[mpc[7:2]];
			a = xr[ins[19:15]];
			b = xr[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			res = '0;
			wr = 1'b0;
			nxt = mpc + 32'd4;
			case (ins[6:0])
				7'b0110011: begin
					res = alu_ref(ins[14:12], ins[30], a, b);
					wr = 1'b1;
				end
				7'b0010011: begin
					res = alu_ref(ins[14:12], 1'b0, a, imm_i);
					wr = 1'b1;
				end
				7'b0000011: begin
					addr = a + imm_i;
					res = dm[addr[5:2]];
					wr = 1'b1;
				end
				7'b0100011: begin
					addr = a + imm_s;
					dm[addr[5:2]] = b;
					exp_addr_q.push_back(addr);
					exp_data_q.push_back(b);
				end
				7'b1100011: begin
					if (a == b) begin
						nxt = mpc + imm_b;
					end
				end
				7'b1101111: begin
					res = mpc + 32'd4;
					wr = 1'b1;
					nxt = mpc + imm_j;
					stop = (nxt == mpc);
				end
				default: begin
				end
			endcase
			if (wr && ins[11:7] != 5'd0) begin
				xr[ins[11:7]] = res;
			end
			final_pc = mpc;
			mpc = nxt;
			steps++;
		end
		model_ok = stop;
		stores_expected = exp_addr_q.size();
	endtask

	task automatic report_test(string name, logic ok);
		tests_run++;
		if (ok) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	// every DUT store against the head of the model's queue
	always @(negedge clock) begin
		if (reset && mem_write) begin
			stores_seen++;
			if (exp_addr_q.size() == 0) begin
				$display("[ERROR] %0t: store of %h to %h beyond the model's stores",
					$time, mem_wdata, mem_addr);
				store_errors++;
			end else begin
				if (mem_addr !== exp_addr_q[0] || mem_wdata !== exp_data_q[0]) begin
					$display("[ERROR] %0t: store of %h to %h, expected %h to %h", $time,
						mem_wdata, mem_addr, exp_data_q[0], exp_addr_q[0]);
					store_errors++;
				end
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
			end
		end
	end

	initial begin
		int   guard;
		int   post;
		logic ok;
		done = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		model_ok = 1'b0;
		final_pc = '0;
		guard = 0;
		do begin
			@(negedge clock);
			guard++;
		end while (prog_valid !== 1'b1 && guard < 20);
		if (prog_valid !== 1'b1) begin
			$display("the program image was never loaded");
		end
		build_model();
		if (!model_ok) begin
			$display("the model never reached a self-looping jal");
		end
		report_test("model_build", prog_valid === 1'b1 && model_ok);

		// through reset and the first three cycles after it
		ok = 1'b1;
		guard = 0;
		post = 0;
		while (post < 3 && guard < 100) begin
			@(negedge clock);
			guard++;
			if (!reset && pc !== `CORE_RESET_PC) begin
				$display("[ERROR] %0t: pc is %h during reset", $time, pc);
				ok = 1'b0;
			end
			if (mem_read !== 1'b0 || mem_write !== 1'b0) begin
				$display("[ERROR] %0t: memory strobe active around reset", $time);
				ok = 1'b0;
			end
			if (reset) begin
				post++;
			end
		end
		if (post < 3) begin
			$display("reset was never released");
			ok = 1'b0;
		end
		report_test("reset_state", ok);

		guard = 0;
		while (pc !== final_pc && guard < 2000) begin
			@(negedge clock);
			guard++;
		end
		if (pc !== final_pc) begin
			$display("pc never reached the final loop at %h within 2000 cycles", final_pc);
		end
		report_test("final_loop", pc === final_pc);

		// let stores already in the pipeline drain
		repeat (8) @(negedge clock);
		report_test("store_values", store_errors == 0);
		if (stores_seen != stores_expected) begin
			$display("[ERROR] %0t: %0d stores seen, model has %0d", $time,
				stores_seen, stores_expected);
		end
		report_test("store_count", stores_seen == stores_expected);
		done = 1'b1;
	end

endmodule

// ==== hdl/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core import isa_pkg::*, pipe_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	output word_t pc,
	input  word_t instr,
	output word_t mem_addr,
	output word_t mem_wdata,
	output logic  mem_read,
	output logic  mem_write,
	input  word_t mem_rdata
);

	// fetch redirect and hold
	logic      stall;
	logic      jump_taken;
	word_t     jump_target;
	logic      branch_taken;
	word_t     branch_target;

	// decode to execute
	word_t     id_pc;
	word_t     id_rs1_val;
	word_t     id_rs2_val;
	word_t     id_imm;
	reg_addr_t id_rs1;
	reg_addr_t id_rs2;
	reg_addr_t id_rd;
	alu_op_e   id_alu_op;
	logic      id_use_imm;
	logic      id_branch;
	logic      id_reg_write;
	logic      id_mem_read;
	logic      id_mem_write;
	wb_src_e   id_wb_src;

	// execute to memory
	reg_addr_t ex_rd;
	logic      ex_mem_read;
	word_t     ex_result;
	word_t     ex_store_data;
	logic      ex_reg_write;
	logic      ex_mem_write;
	wb_src_e   ex_wb_src;

	// writeback back to the register file and forwarding
	reg_addr_t wb_rd;
	logic      wb_en;
	word_t     wb_data;

	fetch_unit u_fetch (.*);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

	result_stage u_result (.*);

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ps

module result_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  reg_addr_t ex_rd,
	input  logic      ex_mem_read,
	input  word_t     ex_result,
	input  word_t     ex_store_data,
	input  logic      ex_reg_write,
	input  logic      ex_mem_write,
	input  wb_src_e   ex_wb_src,
	input  word_t     mem_rdata,
	output word_t     mem_addr,
	output word_t     mem_wdata,
	output logic      mem_read,
	output logic      mem_write,
	output reg_addr_t wb_rd,
	output logic      wb_en,
	output word_t     wb_data
);

	word_t   wb_result;
	wb_src_e wb_sel;

	// word accesses only, the address is the ALU sum
	assign mem_addr = ex_result;
	assign mem_wdata = ex_store_data;
	assign mem_read = ex_mem_read;
	assign mem_write = ex_mem_write;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_en <= 1'b0;
		end else begin
			wb_en <= ex_reg_write;
		end
	end

	always_ff @(posedge clock) begin
		wb_rd <= ex_rd;
		wb_result <= ex_result;
		wb_sel <= ex_wb_src;
	end

	// load data arrives the cycle after the read strobe
	assign wb_data = (wb_sel == wb_load) ? mem_rdata : wb_result;

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  word_t     id_pc,
	input  word_t     id_rs1_val,
	input  word_t     id_rs2_val,
	input  word_t     id_imm,
	input  reg_addr_t id_rs1,
	input  reg_addr_t id_rs2,
	input  reg_addr_t id_rd,
	input  alu_op_e   id_alu_op,
	input  logic      id_use_imm,
	input  logic      id_branch,
	input  logic      id_reg_write,
	input  logic      id_mem_read,
	input  logic      id_mem_write,
	input  wb_src_e   id_wb_src,
	input  reg_addr_t wb_rd,
	input  logic      wb_en,
	input  word_t     wb_data,
	output logic      branch_taken,
	output word_t     branch_target,
	output reg_addr_t ex_rd,
	output logic      ex_mem_read,
	output word_t     ex_result,
	output word_t     ex_store_data,
	output logic      ex_reg_write,
	output logic      ex_mem_write,
	output wb_src_e   ex_wb_src
);

	word_t op_a;
	word_t op_b_reg;
	word_t op_b;
	word_t alu_out;
	word_t result;

	// youngest producer first, the memory stage before writeback
	function automatic word_t forward(reg_addr_t rs, word_t reg_val);
		if (ex_reg_write && ex_rd != '0 && ex_rd == rs) begin
			return ex_result;
		end else if (wb_en && wb_rd != '0 && wb_rd == rs) begin
			return wb_data;
		end
		return reg_val;
	endfunction

	always_comb begin
		op_a = forward(id_rs1, id_rs1_val);
		op_b_reg = forward(id_rs2, id_rs2_val);
	end

	assign op_b = id_use_imm ? id_imm : op_b_reg;

	always_comb begin
		case (id_alu_op)
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or:  alu_out = op_a | op_b;
			alu_xor: alu_out = op_a ^ op_b;
			alu_slt: alu_out = word_t'($signed(op_a) < $signed(op_b));
			default: alu_out = op_a + op_b;
		endcase
	end

	// jal writes its return address
	assign result = (id_wb_src == wb_link) ? id_pc + word_t'(4) : alu_out;

	// beq only
	assign branch_taken = id_branch && (op_a == op_b_reg);
	assign branch_target = id_pc + id_imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end else begin
			ex_reg_write <= id_reg_write;
			ex_mem_read <= id_mem_read;
			ex_mem_write <= id_mem_write;
		end
	end

	always_ff @(posedge clock) begin
		ex_rd <= id_rd;
		ex_result <= result;
		ex_store_data <= op_b_reg;
		ex_wb_src <= id_wb_src;
	end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  word_t     instr,
	input  word_t     pc,
	input  logic      branch_taken,
	input  reg_addr_t wb_rd,
	input  logic      wb_en,
	input  word_t     wb_data,
	output logic      stall,
	output logic      jump_taken,
	output word_t     jump_target,
	output word_t     id_pc,
	output word_t     id_rs1_val,
	output word_t     id_rs2_val,
	output word_t     id_imm,
	output reg_addr_t id_rs1,
	output reg_addr_t id_rs2,
	output reg_addr_t id_rd,
	output alu_op_e   id_alu_op,
	output logic      id_use_imm,
	output logic      id_branch,
	output logic      id_reg_write,
	output logic      id_mem_read,
	output logic      id_mem_write,
	output wb_src_e   id_wb_src
);

	localparam int reg_count = 1 << `CORE_REG_ADDR_W;

	word_t     if_pc;
	word_t     if_instr;
	logic      if_valid;
	r_fields_t f;
	word_t     imm_i;
	word_t     imm_s;
	word_t     imm_b;
	word_t     imm_j;
	word_t     imm;
	alu_op_e   alu_op;
	wb_src_e   wb_src;
	logic      use_imm;
	logic      is_branch;
	logic      is_jal;
	logic      reg_write;
	logic      mem_read;
	logic      mem_write;
	logic      use_rs1;
	logic      use_rs2;
	word_t     rs1_val;
	word_t     rs2_val;
	word_t     regs [0:reg_count-1];

	function automatic alu_op_e alu_from_funct3(funct3_e f3, logic sub);
		case (f3)
			f3_add:  return sub ? alu_sub : alu_add;
			f3_slt:  return alu_slt;
			f3_xor:  return alu_xor;
			f3_or:   return alu_or;
			f3_and:  return alu_and;
			default: return alu_add;
		endcase
	endfunction

	// x0 reads zero and a same-cycle writeback wins over the array
	function automatic word_t read_reg(reg_addr_t a);
		if (a == '0) begin
			return '0;
		end else if (wb_en && wb_rd == a) begin
			return wb_data;
		end
		return regs[a];
	endfunction

	// fetch/decode register is emptied on any redirect
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			if_valid <= 1'b0;
		end else if (branch_taken || jump_taken) begin
			if_valid <= 1'b0;
		end else if (!stall) begin
			if_valid <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			if_pc <= pc;
			if_instr <= instr;
		end
	end

	assign f = r_fields_t'(if_instr);
	assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
		if_instr[11:8], 1'b0};
	assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
		if_instr[30:21], 1'b0};

	always_comb begin
		alu_op = alu_add;
		wb_src = wb_alu;
		imm = imm_i;
		use_imm = 1'b0;
		is_branch = 1'b0;
		is_jal = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (f.opcode)
			opc_op: begin
				alu_op = alu_from_funct3(f.funct3, f.funct7[5]);
				reg_write = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			opc_op_imm: begin
				// no subi in the ISA
				alu_op = alu_from_funct3(f.funct3, 1'b0);
				use_imm = 1'b1;
				reg_write = 1'b1;
				use_rs1 = 1'b1;
			end
			opc_load: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
				wb_src = wb_load;
				use_rs1 = 1'b1;
			end
			opc_store: begin
				imm = imm_s;
				use_imm = 1'b1;
				mem_write = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			opc_branch: begin
				imm = imm_b;
				is_branch = (f.funct3 == f3_beq);
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			opc_jal: begin
				imm = imm_j;
				is_jal = 1'b1;
				reg_write = 1'b1;
				wb_src = wb_link;
			end
			default: begin
			end
		endcase
	end

	// load in execute feeding the instruction in decode
	assign stall = if_valid && id_mem_read && id_rd != '0 &&
		((use_rs1 && f.rs1 == id_rd) || (use_rs2 && f.rs2 == id_rd));

	assign jump_taken = if_valid && is_jal;
	assign jump_target = if_pc + imm_j;

	always_comb begin
		rs1_val = read_reg(f.rs1);
		rs2_val = read_reg(f.rs2);
	end

	always_ff @(posedge clock) begin
		if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// decode/execute register takes a bubble on stall, flush or empty slot
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_branch <= 1'b0;
			id_reg_write <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
		end else if (branch_taken || stall || !if_valid) begin
			id_branch <= 1'b0;
			id_reg_write <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
		end else begin
			id_branch <= is_branch;
			id_reg_write <= reg_write;
			id_mem_read <= mem_read;
			id_mem_write <= mem_write;
		end
	end

	always_ff @(posedge clock) begin
		id_pc <= if_pc;
		id_rs1_val <= rs1_val;
		id_rs2_val <= rs2_val;
		id_imm <= imm;
		id_rs1 <= f.rs1;
		id_rs2 <= f.rs2;
		id_rd <= f.rd;
		id_alu_op <= alu_op;
		id_use_imm <= use_imm;
		id_wb_src <= wb_src;
	end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_unit import isa_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  stall,
	input  logic  jump_taken,
	input  word_t jump_target,
	input  logic  branch_taken,
	input  word_t branch_target,
	output word_t pc
);

	word_t pc_next;

	// a branch resolved in execute is older than a jal in decode
	always_comb begin
		if (branch_taken) begin
			pc_next = branch_target;
		end else if (jump_taken) begin
			pc_next = jump_target;
		end else if (stall) begin
			pc_next = pc;
		end else begin
			pc_next = pc + word_t'(4);
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= `CORE_RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

	// operation carried from decode into execute
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5
	} alu_op_e;

	// what ends up in rd
	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_load = 2'd1,
		wb_link = 2'd2
	} wb_src_e;

endpackage

// ==== hdl/isa_pkg.sv ====
`include "core_params.svh"

package isa_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111
	} opcode_e;

	// lw and sw also carry 3'b010 here
	typedef enum logic [2:0] {
		f3_add = 3'b000,
		f3_slt = 3'b010,
		f3_xor = 3'b100,
		f3_or  = 3'b110,
		f3_and = 3'b111
	} funct3_e;

	// beq shares its encoding with add
	localparam funct3_e f3_beq = f3_add;

	// R format view, the other formats reuse opcode, rd, funct3 and rs1
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		funct3_e    funct3;
		reg_addr_t  rd;
		opcode_e    opcode;
	} r_fields_t;

endpackage

// ==== hdl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define CORE_XLEN 32

// register index width, 32 registers
`define CORE_REG_ADDR_W 5

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

`endif
